// ==== Bender.yml ====
package:
  name: ex_pipe

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ex_pkg.sv
      - hdl/id_stage.sv
      - hdl/id_ex_pipe.sv
      - hdl/alu.sv
      - hdl/mult.sv
      - hdl/ex_stage.sv
      - hdl/ex_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ex_checker.sv
      - test/tb_ex_top.sv

// ==== hdl/alu.sv ====
//////////////////////////////
// Single-cycle ALU with branch compare flag
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module alu
(
  input  ex_pkg::alu_op_e     operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_o
);

  import ex_pkg::*;

  logic is_lt;
  logic is_eq;

  // Signed compare shared by SLT and BLT
  assign is_lt = $signed(operand_a_i) < $signed(operand_b_i);
  assign is_eq = (operand_a_i == operand_b_i);

  always_comb
  begin
    result_o = '0;
    cmp_o    = 1'b0;
    case (operator_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      ALU_SLT: result_o = {{(`EX_XLEN-1){1'b0}}, is_lt};
      // Compare-only ops for branches
      ALU_EQ:  cmp_o = is_eq;
      ALU_LT:  cmp_o = is_lt;
      default: ;
    endcase
  end

endmodule

// ==== hdl/ex_config.svh ====
//////////////////////////////
// Build-time sizes for the execute pipeline
// Include in any file that needs a width or a count
//////////////////////////////

`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Data path width in bits
`define EX_XLEN 32

// Architectural register count
// Register 0 always reads as zero
`define EX_NREGS 16

// Multiplier bits retired per cycle, must divide EX_XLEN
`define EX_MULT_BITS 8

`endif

// ==== hdl/ex_pkg.sv ====
//////////////////////////////
// Types shared by decode, the ID/EX register and execute
//////////////////////////////

`include "ex_config.svh"

package ex_pkg;

  // Register index sized from the register count
  typedef logic [$clog2(`EX_NREGS)-1:0] reg_addr_t;
  // Unused top bits of the 5-bit RISC-V register fields
  typedef logic [4-$clog2(`EX_NREGS):0] reg_pad_t;

  // Major opcodes with their RISC-V encodings
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operations, EQ and LT only drive the compare flag
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_EQ,
    ALU_LT
  } alu_op_e;

  //////////////////////////////
  // Instruction word views
  //////////////////////////////

  // Register-register layout, also used by branches
  typedef struct packed {
    logic [6:0] funct7;
    reg_pad_t   rs2_pad;
    reg_addr_t  rs2;
    reg_pad_t   rs1_pad;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_pad_t   rd_pad;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } instr_r_t;

  // Register-immediate layout
  typedef struct packed {
    logic [11:0] imm12;
    reg_pad_t    rs1_pad;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_pad_t    rd_pad;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  //////////////////////////////
  // Pipeline payloads
  //////////////////////////////

  // Decoded item from ID to EX
  // operand_c holds the branch offset
  typedef struct packed {
    logic                alu_en;
    logic                mult_en;
    logic                branch_in;
    alu_op_e             alu_op;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [`EX_XLEN-1:0] operand_c;
    logic                regfile_we;
    reg_addr_t           regfile_waddr;
  } id_ex_pipe_t;

  // Register file write, also the forwarding format
  typedef struct packed {
    logic                we;
    reg_addr_t           waddr;
    logic [`EX_XLEN-1:0] wdata;
  } wb_port_t;

  // One-cycle branch outcome report
  typedef struct packed {
    logic                valid;
    logic                taken;
    logic [`EX_XLEN-1:0] target;
  } branch_res_t;

endpackage

// ==== hdl/ex_stage.sv ====
//////////////////////////////
// Execute stage with ALU, multiplier and EX/WB register
// Also reports branch outcomes and forwards its result to decode
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module ex_stage
(
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::id_ex_pipe_t pipe_i,
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output ex_pkg::wb_port_t    fw_o,
  output logic                busy_dest_o,
  output ex_pkg::wb_port_t    wb_o,
  output ex_pkg::branch_res_t branch_o
);

  import ex_pkg::*;

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;
  logic                mult_busy;
  logic                ex_valid;
  logic                wb_we_q;
  reg_addr_t           wb_waddr_q;
  logic [`EX_XLEN-1:0] wb_wdata_q;
  logic                br_valid_q;
  logic                br_taken_q;
  logic [`EX_XLEN-1:0] br_target_q;

  alu alu_inst
  (
    .operator_i  (pipe_i.alu_op),
    .operand_a_i (pipe_i.operand_a),
    .operand_b_i (pipe_i.operand_b),
    .result_o    (alu_result),
    .cmp_o       (alu_cmp)
  );

  mult mult_inst
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (pipe_i.mult_en),
    .op_a_i     (pipe_i.operand_a),
    .op_b_i     (pipe_i.operand_b),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready),
    .busy_o     (mult_busy)
  );

  // Result select onto the forwarding port
  always_comb
  begin
    fw_o.we    = pipe_i.regfile_we;
    fw_o.waddr = pipe_i.regfile_waddr;
    fw_o.wdata = '0;
    if (pipe_i.alu_en)
      fw_o.wdata = alu_result;
    if (pipe_i.mult_en)
      fw_o.wdata = mult_result;
  end

  // Multiply still running with a pending register write
  assign busy_dest_o = mult_busy & pipe_i.regfile_we;

  // Branches never wait since they skip write-back
  assign ex_ready_o = (mult_ready & wb_ready_i) | pipe_i.branch_in;
  assign ex_valid   = (pipe_i.alu_en | pipe_i.mult_en) & mult_ready & wb_ready_i;

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  // we pulses once per result so a stalled WB never repeats a write
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      wb_we_q <= 1'b0;
    else if (ex_valid)
      wb_we_q <= pipe_i.regfile_we;
    else
      wb_we_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (ex_valid)
    begin
      wb_waddr_q <= pipe_i.regfile_waddr;
      wb_wdata_q <= fw_o.wdata;
    end
  end

  assign wb_o = '{we: wb_we_q, waddr: wb_waddr_q, wdata: wb_wdata_q};

  //////////////////////////////
  // Branch report
  //////////////////////////////

  // A branch always leaves EX in its first cycle
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      br_valid_q <= 1'b0;
    else
      br_valid_q <= pipe_i.branch_in;
  end

  always_ff @(posedge clk)
  begin
    if (pipe_i.branch_in)
    begin
      br_taken_q  <= alu_cmp;
      br_target_q <= pipe_i.operand_c;
    end
  end

  assign branch_o = '{valid: br_valid_q, taken: br_taken_q, target: br_target_q};

endmodule

// ==== hdl/ex_top.sv ====
//////////////////////////////
// Top level of the decode and execute pipeline
//////////////////////////////

`timescale 1ns/10ps

module ex_top
(
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::instr_u      instr_i,
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  logic                wb_ready_i,
  output ex_pkg::wb_port_t    wb_o,
  output ex_pkg::branch_res_t branch_o
);

  import ex_pkg::*;

  id_ex_pipe_t issue;
  logic        issue_valid;
  id_ex_pipe_t pipe;
  logic        ex_ready;
  logic        busy_dest;
  wb_port_t    fw;

  // Producer
  id_stage id_stage_inst
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .ex_ready_i     (ex_ready),
    .ex_busy_dest_i (busy_dest),
    .fw_i           (fw),
    .wb_i           (wb_o),
    .issue_o        (issue),
    .issue_valid_o  (issue_valid),
    .instr_ready_o  (instr_ready_o)
  );

  // ID/EX buffer
  id_ex_pipe id_ex_pipe_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .issue_i       (issue),
    .issue_valid_i (issue_valid),
    .ex_ready_i    (ex_ready),
    .pipe_o        (pipe)
  );

  // Consumer
  ex_stage ex_stage_inst
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .pipe_i      (pipe),
    .wb_ready_i  (wb_ready_i),
    .ex_ready_o  (ex_ready),
    .fw_o        (fw),
    .busy_dest_o (busy_dest),
    .wb_o        (wb_o),
    .branch_o    (branch_o)
  );

endmodule

// ==== hdl/id_ex_pipe.sv ====
//////////////////////////////
// ID/EX pipeline register between decode and execute
//////////////////////////////

`timescale 1ns/10ps

module id_ex_pipe
(
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::id_ex_pipe_t issue_i,
  input  logic                issue_valid_i,
  input  logic                ex_ready_i,
  output ex_pkg::id_ex_pipe_t pipe_o
);

  import ex_pkg::*;

  id_ex_pipe_t pipe_q;

  // Advance whenever EX takes its item
  // An empty slot becomes an all-zero bubble
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      pipe_q <= '0;
    end
    else if (ex_ready_i)
    begin
      if (issue_valid_i)
        pipe_q <= issue_i;
      else
        pipe_q <= '0;
    end
  end

  assign pipe_o = pipe_q;

endmodule

// ==== hdl/id_stage.sv ====
//////////////////////////////
// Decode stage with register file and operand forwarding
// Feeds the ID/EX register combinationally
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module id_stage
(
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::instr_u      instr_i,
  input  logic                instr_valid_i,
  input  logic                ex_ready_i,
  input  logic                ex_busy_dest_i,
  input  ex_pkg::wb_port_t    fw_i,
  input  ex_pkg::wb_port_t    wb_i,
  output ex_pkg::id_ex_pipe_t issue_o,
  output logic                issue_valid_o,
  output logic                instr_ready_o
);

  import ex_pkg::*;

  logic [`EX_XLEN-1:0] rf [`EX_NREGS];
  reg_addr_t           rs1;
  reg_addr_t           rs2;
  logic [`EX_XLEN-1:0] rs1_val;
  logic [`EX_XLEN-1:0] rs2_val;
  logic [`EX_XLEN-1:0] imm_i;
  logic [11:0]         br_off;
  logic [`EX_XLEN-1:0] imm_b;
  logic                rs1_used;
  logic                rs2_used;
  logic                hazard;

  // Forwarding priority: EX result, then WB, then stored value
  function automatic logic [`EX_XLEN-1:0] read_reg(input reg_addr_t addr,
                                                  input wb_port_t fw,
                                                  input wb_port_t wb,
                                                  input logic [`EX_XLEN-1:0] stored);
    logic [`EX_XLEN-1:0] val;
    if (addr == '0)
      val = '0;
    else if (fw.we && (fw.waddr == addr))
      val = fw.wdata;
    else if (wb.we && (wb.waddr == addr))
      val = wb.wdata;
    else
      val = stored;
    return val;
  endfunction

  //////////////////////////////
  // Register file
  //////////////////////////////

  // Cleared on reset so the architectural state starts at zero
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `EX_NREGS; i++)
        rf[i] <= '0;
    end
    else if (wb_i.we)
    begin
      rf[wb_i.waddr] <= wb_i.wdata;
    end
  end

  assign rs1     = instr_i.r.rs1;
  assign rs2     = instr_i.r.rs2;
  assign rs1_val = read_reg(rs1, fw_i, wb_i, rf[rs1]);
  assign rs2_val = read_reg(rs2, fw_i, wb_i, rf[rs2]);

  // I-type immediate, sign extended
  assign imm_i  = {{(`EX_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
  // Branch offset sits in the funct7 and full rd fields
  assign br_off = {instr_i.r.funct7, instr_i.r.rd_pad, instr_i.r.rd};
  assign imm_b  = {{(`EX_XLEN-12){br_off[11]}}, br_off};

  //////////////////////////////
  // Decoder
  //////////////////////////////

  always_comb
  begin
    issue_o               = '0;
    rs1_used              = 1'b0;
    rs2_used              = 1'b0;
    issue_o.operand_a     = rs1_val;
    issue_o.operand_b     = rs2_val;
    issue_o.regfile_waddr = instr_i.r.rd;

    case (instr_i.r.opcode)
      OPC_OP:
      begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'b0000000, 3'b000}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_ADD; end
          {7'b0100000, 3'b000}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_SUB; end
          {7'b0000000, 3'b111}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_AND; end
          {7'b0000000, 3'b110}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_OR;  end
          {7'b0000000, 3'b100}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_XOR; end
          {7'b0000000, 3'b010}: begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_SLT; end
          // MUL goes to the multicycle unit
          {7'b0000001, 3'b000}: issue_o.mult_en = 1'b1;
          default: ;
        endcase
      end
      OPC_OP_IMM:
      begin
        rs1_used          = 1'b1;
        issue_o.operand_b = imm_i;
        case (instr_i.i.funct3)
          3'b000:  begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_ADD; end
          3'b100:  begin issue_o.alu_en = 1'b1; issue_o.alu_op = ALU_XOR; end
          default: ;
        endcase
      end
      OPC_BRANCH:
      begin
        rs1_used          = 1'b1;
        rs2_used          = 1'b1;
        issue_o.operand_c = imm_b;
        case (instr_i.r.funct3)
          3'b000:  begin issue_o.branch_in = 1'b1; issue_o.alu_op = ALU_EQ; end
          3'b100:  begin issue_o.branch_in = 1'b1; issue_o.alu_op = ALU_LT; end
          default: ;
        endcase
      end
      // Unknown opcode decodes to a no-op
      default: ;
    endcase

    // Writes to register 0 are dropped here
    issue_o.regfile_we = (issue_o.alu_en | issue_o.mult_en) & (instr_i.r.rd != '0);
  end

  // Hold while a source waits on an unfinished multiply in EX
  assign hazard = ex_busy_dest_i &
                  ((rs1_used & (rs1 == fw_i.waddr)) | (rs2_used & (rs2 == fw_i.waddr)));

  assign instr_ready_o = ex_ready_i & ~hazard;
  assign issue_valid_o = instr_valid_i & ~hazard;

endmodule

// ==== hdl/mult.sv ====
//////////////////////////////
// Iterative shift-add multiplier, low word of the product
// Retires EX_MULT_BITS multiplier bits per cycle
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module mult
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                busy_o
);

  localparam int unsigned MB    = `EX_MULT_BITS;
  localparam int unsigned STEPS = `EX_XLEN / MB;
  localparam int unsigned CW    = (STEPS > 1) ? $clog2(STEPS) : 1;

  logic [CW-1:0]       step_q;
  logic [`EX_XLEN-1:0] acc_q;
  logic [MB-1:0]       chunk;
  logic [`EX_XLEN-1:0] partial;
  logic                last;

  assign last  = (step_q == CW'(STEPS - 1));
  // Multiplier slice handled in this step
  assign chunk = MB'(op_b_i >> (step_q * MB));

  // Shifted copies of the multiplicand for each set bit
  always_comb
  begin
    partial = '0;
    for (int j = 0; j < MB; j++)
    begin
      if (chunk[j])
        partial = partial + (op_a_i << (step_q * MB + j));
    end
  end

  // Operands stay put in the ID/EX register while busy
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      step_q <= '0;
      acc_q  <= '0;
    end
    else if (start_i && !last)
    begin
      acc_q  <= acc_q + partial;
      step_q <= step_q + 1'b1;
    end
    else if (!start_i || ex_ready_i)
    begin
      // Idle, or the finished product was taken
      acc_q  <= '0;
      step_q <= '0;
    end
  end

  // Last step adds its slice combinationally
  assign result_o = acc_q + partial;
  assign ready_o  = ~start_i | last;
  assign busy_o   = start_i & ~last;

endmodule

// ==== list.f ====
+incdir+hdl
hdl/ex_pkg.sv
hdl/id_stage.sv
hdl/id_ex_pipe.sv
hdl/alu.sv
hdl/mult.sv
hdl/ex_stage.sv
hdl/ex_top.sv
test/ex_checker.sv
test/tb_ex_top.sv

// ==== test/ex_checker.sv ====
//////////////////////////////
// Reference model and stream compare for the execute pipeline
// Watches the DUT ports and counts mismatches
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module ex_checker
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [31:0]         instr_i,
  input  logic                instr_valid_i,
  input  logic                instr_ready_i,
  input  ex_pkg::wb_port_t    wb_i,
  input  ex_pkg::branch_res_t branch_i,
  output int                  wb_err_o,
  output int                  br_err_o,
  output int                  misc_err_o,
  output logic                drained_o
);

  localparam int AW = $clog2(`EX_NREGS);

  // Architectural register state, x0 is never written
  logic [`EX_XLEN-1:0]    regs [`EX_NREGS];
  // Expected writes as {addr, data}, branches as {taken, target}
  logic [AW+`EX_XLEN-1:0] exp_wb [$];
  logic [`EX_XLEN:0]      exp_br [$];
  logic                   in_reset;

  //////////////////////////////
  // In-order model
  //////////////////////////////

  task automatic retire(input logic [31:0] w);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] imm;
    logic [`EX_XLEN-1:0] off;
    logic [`EX_XLEN-1:0] res;
    logic [AW-1:0]       rd;
    logic                wr;
    a   = regs[w[15 +: AW]];
    b   = regs[w[20 +: AW]];
    rd  = w[7 +: AW];
    // I-type immediate and branch offset, both sign extended from 12 bits
    imm = {{(`EX_XLEN-12){w[31]}}, w[31:20]};
    off = {{(`EX_XLEN-12){w[31]}}, w[31:25], w[11:7]};
    res = '0;
    wr  = 1'b1;
    case (w[6:0])
      7'b0110011:
      begin
        case ({w[31:25], w[14:12]})
          {7'h00, 3'b000}: res = a + b;
          {7'h20, 3'b000}: res = a - b;
          {7'h00, 3'b111}: res = a & b;
          {7'h00, 3'b110}: res = a | b;
          {7'h00, 3'b100}: res = a ^ b;
          {7'h00, 3'b010}: res = {{(`EX_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
          // Low word of the product, same for signed and unsigned
          {7'h01, 3'b000}: res = a * b;
          default:         wr = 1'b0;
        endcase
      end
      7'b0010011:
      begin
        if (w[14:12] == 3'b000)
          res = a + imm;
        else if (w[14:12] == 3'b100)
          res = a ^ imm;
        else
          wr = 1'b0;
      end
      7'b1100011:
      begin
        wr = 1'b0;
        if (w[14:12] == 3'b000)
          exp_br.push_back({a == b, off});
        else if (w[14:12] == 3'b100)
          exp_br.push_back({$signed(a) < $signed(b), off});
      end
      // Anything else retires as a no-op
      default: wr = 1'b0;
    endcase
    if (wr && (rd != '0))
    begin
      regs[rd] = res;
      exp_wb.push_back({rd, res});
    end
  endtask

  task automatic check_write();
    logic [AW+`EX_XLEN-1:0] want;
    if (exp_wb.size() == 0)
    begin
      $display("write to register %0d appeared with no instruction waiting for it", wb_i.waddr);
      misc_err_o = misc_err_o + 1;
    end
    else
    begin
      want = exp_wb.pop_front();
      if (wb_i.waddr !== want[`EX_XLEN +: AW])
      begin
        $display("error wb_o.waddr expected %h got %h", want[`EX_XLEN +: AW], wb_i.waddr);
        wb_err_o = wb_err_o + 1;
      end
      if (wb_i.wdata !== want[`EX_XLEN-1:0])
      begin
        $display("error wb_o.wdata expected %h got %h", want[`EX_XLEN-1:0], wb_i.wdata);
        wb_err_o = wb_err_o + 1;
      end
    end
  endtask

  task automatic check_branch();
    logic [`EX_XLEN:0] want;
    if (exp_br.size() == 0)
    begin
      $display("branch report appeared with no branch waiting for it");
      misc_err_o = misc_err_o + 1;
    end
    else
    begin
      want = exp_br.pop_front();
      if (branch_i.taken !== want[`EX_XLEN])
      begin
        $display("error branch_o.taken expected %h got %h", want[`EX_XLEN], branch_i.taken);
        br_err_o = br_err_o + 1;
      end
      if (branch_i.target !== want[`EX_XLEN-1:0])
      begin
        $display("error branch_o.target expected %h got %h", want[`EX_XLEN-1:0],
                 branch_i.target);
        br_err_o = br_err_o + 1;
      end
    end
  endtask

  //////////////////////////////
  // Sampling
  //////////////////////////////

  // All ports sampled at the rising edge, before this edge's updates
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      in_reset = 1'b1;
      for (int k = 0; k < `EX_NREGS; k++)
        regs[k] = '0;
      exp_wb.delete();
      exp_br.delete();
    end
    else
    begin
      // First cycle out of reset
      if (in_reset)
      begin
        if (wb_i.we !== 1'b0)
        begin
          $display("error wb_o.we expected %h got %h", 1'b0, wb_i.we);
          misc_err_o = misc_err_o + 1;
        end
        if (branch_i.valid !== 1'b0)
        begin
          $display("error branch_o.valid expected %h got %h", 1'b0, branch_i.valid);
          misc_err_o = misc_err_o + 1;
        end
        if (instr_ready_i !== 1'b1)
        begin
          $display("error instr_ready_o expected %h got %h", 1'b1, instr_ready_i);
          misc_err_o = misc_err_o + 1;
        end
        in_reset = 1'b0;
      end
      if (wb_i.we === 1'b1)
        check_write();
      if (branch_i.valid === 1'b1)
        check_branch();
      // Accepted word updates the model
      if (instr_valid_i && instr_ready_i)
        retire(instr_i);
    end
    drained_o <= (exp_wb.size() == 0) && (exp_br.size() == 0);
  end

endmodule

// ==== test/tb_ex_top.sv ====
//////////////////////////////
// Testbench for the execute pipeline top level
// Random instruction stream with random write-back stalls
//////////////////////////////

`timescale 1ns/10ps
`include "ex_config.svh"

module tb_ex_top;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int N_INSTR      = 400;
  localparam int AW           = $clog2(`EX_NREGS);
  localparam int MUL_CYCLES   = `EX_XLEN / `EX_MULT_BITS;
  localparam int STALL_MARGIN = 3;
  // Budget per instruction covers a multiply, one issue cycle and a stall margin
  // Four times that leaves room for back-pressure
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + N_INSTR * (MUL_CYCLES + 1 + STALL_MARGIN) * 4) * CLK_PERIOD;

  // Major opcodes for the generator
  localparam logic [6:0] OPC_R   = 7'b0110011;
  localparam logic [6:0] OPC_I   = 7'b0010011;
  localparam logic [6:0] OPC_B   = 7'b1100011;
  localparam logic [6:0] OPC_BAD = 7'b0000011;

  logic                clk = 1'b0;
  logic                rst_n;
  logic [31:0]         instr;
  logic                instr_valid;
  logic                instr_ready;
  logic                wb_ready;
  ex_pkg::wb_port_t    wb;
  ex_pkg::branch_res_t branch;
  int                  wb_err;
  int                  br_err;
  int                  misc_err;
  logic                drained;
  logic [31:0]         lfsr_state = 32'hf01b;
  logic [AW-1:0]       last_rd    = AW'(1);
  int                  sent;
  logic                pending;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // One Galois step of the polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'h80200003;
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // Random word with the opcode and function fields forced to one instruction
  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [3:0]  kind;
    w    = rand_bits(32);
    kind = 4'(rand_bits(4));
    // Reuse the last destination to build dependence chains
    if (rand_bits(1) != 0)
      w[15 +: AW] = last_rd;
    if (rand_bits(2) == 0)
      w[20 +: AW] = last_rd;
    case (kind)
      4'd0, 4'd1:       {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'b000, OPC_R};
      4'd2:             {w[31:25], w[14:12], w[6:0]} = {7'h20, 3'b000, OPC_R};
      4'd3:             {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'b111, OPC_R};
      4'd4:             {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'b110, OPC_R};
      4'd5:             {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'b100, OPC_R};
      4'd6:             {w[31:25], w[14:12], w[6:0]} = {7'h00, 3'b010, OPC_R};
      4'd7, 4'd8, 4'd14: {w[31:25], w[14:12], w[6:0]} = {7'h01, 3'b000, OPC_R};
      4'd9, 4'd10:      {w[14:12], w[6:0]} = {3'b000, OPC_I};
      4'd11:            {w[14:12], w[6:0]} = {3'b100, OPC_I};
      4'd12:            {w[14:12], w[6:0]} = {3'b000, OPC_B};
      4'd13:            {w[14:12], w[6:0]} = {3'b100, OPC_B};
      // Undefined opcode that must write nothing
      default:          w[6:0] = OPC_BAD;
    endcase
    if ((kind < 4'd12) || (kind == 4'd14))
      last_rd = w[7 +: AW];
    return w;
  endfunction

  ex_top ex_top_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .wb_ready_i    (wb_ready),
    .wb_o          (wb),
    .branch_o      (branch)
  );

  ex_checker checker_inst
  (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_i       (instr),
    .instr_valid_i (instr_valid),
    .instr_ready_i (instr_ready),
    .wb_i          (wb),
    .branch_i      (branch),
    .wb_err_o      (wb_err),
    .br_err_o      (br_err),
    .misc_err_o    (misc_err),
    .drained_o     (drained)
  );

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial
  begin
    rst_n       = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    wb_ready    = 1'b1;
    sent        = 0;
    pending     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    while (sent < N_INSTR)
    begin
      @(posedge clk);
      // Handshake seen with the values from before this edge
      if (instr_valid && instr_ready)
      begin
        sent++;
        pending = 1'b0;
      end
      // Back-pressure about one cycle in four
      wb_ready <= (rand_bits(2) != 0);
      if (!pending && (sent < N_INSTR) && (rand_bits(2) != 0))
      begin
        instr       <= make_instr();
        instr_valid <= 1'b1;
        pending     = 1'b1;
      end
      else if (!pending)
      begin
        instr_valid <= 1'b0;
      end
    end
    instr_valid <= 1'b0;
    wb_ready    <= 1'b1;

    // Drain until every expected write and branch report was seen
    @(posedge clk);
    while (!drained)
      @(posedge clk);
    // Idle cycles expose any late duplicate write
    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("error counts: write %0d, branch %0d, other %0d", wb_err, br_err, misc_err);
    if ((wb_err + br_err + misc_err) == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: the pipeline did not retire all %0d instructions in %0d ns",
             N_INSTR, WATCHDOG_NS);
    $display("error counts: write %0d, branch %0d, other %0d", wb_err, br_err, misc_err);
    $display("Done: errors found");
    $finish;
  end

endmodule
